//--- src/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Data path and address width of the integer core
`define XLEN_BITS 32

// Word address width of the data memory
// 8 bits gives 256 words (1 KiB)
`define DMEM_ADDR_BITS 8

// Byte lanes in one data word
`define XLEN_BYTES (`XLEN_BITS / 8)

// Width of a register index
`define REG_ADDR_BITS 5

`endif

//--- src/riscv_pkg.sv
`default_nettype none

`include "riscv_defines.svh"

package riscv_pkg;

    // ALU operation select
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10
    } aluOp;

    // Writeback source select
    typedef enum logic [1:0] {
        resAlu   = 2'b00,
        resLoad  = 2'b01,
        resIncPc = 2'b10
    } resultSrc;

    // Branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Load and store sizes
    // Stores use the signed codes
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    // ID/EX contents
    typedef struct packed {
        logic                       valid;
        logic                       jump;
        logic                       branch;
        logic                       regWrite;
        logic                       memWrite;
        resultSrc                   resultSel;
        aluOp                       aluCtrl;
        logic                       srcASel;
        logic                       srcBSel;
        logic [`XLEN_BITS-1:0]      rs1;
        logic [`XLEN_BITS-1:0]      rs2;
        logic [`XLEN_BITS-1:0]      imm;
        logic [`XLEN_BITS-1:0]      pc;
        logic [`XLEN_BITS-1:0]      incPc;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_BITS-1:0]  rd;
    } exBundle;

    // EX/MEM contents
    typedef struct packed {
        logic                       valid;
        logic                       regWrite;
        logic                       memWrite;
        resultSrc                   resultSel;
        logic [`XLEN_BITS-1:0]      aluOut;
        logic [`XLEN_BITS-1:0]      rs2;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_BITS-1:0]  rd;
        logic [`XLEN_BITS-1:0]      incPc;
    } exMem;

    // Writeback port
    typedef struct packed {
        logic                       valid;
        logic                       regWrite;
        logic [`REG_ADDR_BITS-1:0]  rd;
        logic [`XLEN_BITS-1:0]      result;
    } memWb;

endpackage

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module alu (
    input  logic [`XLEN_BITS-1:0]   opA,
    input  logic [`XLEN_BITS-1:0]   opB,
    input  riscv_pkg::aluOp         ctrl,
    output logic [`XLEN_BITS-1:0]   result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    // RV32I shifts only look at the low five bits
    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (ctrl)
            riscv_pkg::aluAdd:   result = opA + opB;
            riscv_pkg::aluSub:   result = opA - opB;
            riscv_pkg::aluSll:   result = opA << shamt;
            riscv_pkg::aluSlt:   result = {{(`XLEN_BITS-1){1'b0}}, ltSigned};
            riscv_pkg::aluSltu:  result = {{(`XLEN_BITS-1){1'b0}}, ltUnsigned};
            riscv_pkg::aluXor:   result = opA ^ opB;
            riscv_pkg::aluSrl:   result = opA >> shamt;
            riscv_pkg::aluSra:   result = $unsigned($signed(opA) >>> shamt);
            riscv_pkg::aluOr:    result = opA | opB;
            riscv_pkg::aluAnd:   result = opA & opB;
            // lui passes the shifted immediate through
            riscv_pkg::aluPassB: result = opB;
            default:             result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/branchCompare.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module branchCompare (
    input  logic [`XLEN_BITS-1:0]   rs1,
    input  logic [`XLEN_BITS-1:0]   rs2,
    input  logic [2:0]              funct3,
    output logic                    taken
);

    logic isEq;
    logic isLt;
    logic isLtu;

    assign isEq  = rs1 == rs2;
    assign isLt  = $signed(rs1) < $signed(rs2);
    assign isLtu = rs1 < rs2;

    always_comb begin
        case (funct3)
            riscv_pkg::f3Beq:  taken = isEq;
            riscv_pkg::f3Bne:  taken = !isEq;
            riscv_pkg::f3Blt:  taken = isLt;
            riscv_pkg::f3Bge:  taken = !isLt;
            riscv_pkg::f3Bltu: taken = isLtu;
            riscv_pkg::f3Bgeu: taken = !isLtu;
            default:           taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module execute (
    input  logic                    clk,
    input  logic                    rstN,
    input  riscv_pkg::exBundle      ex,
    output logic                    pcSrc,
    output logic [`XLEN_BITS-1:0]   pcTarget,
    output riscv_pkg::exMem         exMemQ
);

    logic [`XLEN_BITS-1:0]  srcA;
    logic [`XLEN_BITS-1:0]  srcB;
    logic [`XLEN_BITS-1:0]  aluOut;
    logic                   relation;
    riscv_pkg::exMem        exMemD;

    // PC for auipc and jal, rs1 otherwise
    assign srcA = ex.srcASel ? ex.pc : ex.rs1;
    assign srcB = ex.srcBSel ? ex.imm : ex.rs2;

    branchCompare i_branchCompare (
        .rs1    (ex.rs1),
        .rs2    (ex.rs2),
        .funct3 (ex.funct3),
        .taken  (relation)
    );

    alu i_alu (
        .opA    (srcA),
        .opB    (srcB),
        .ctrl   (ex.aluCtrl),
        .result (aluOut)
    );

    // Jump and branch targets both come out of the ALU
    assign pcSrc    = ex.valid & (ex.jump | (ex.branch & relation));
    assign pcTarget = aluOut;

    always_comb begin
        exMemD.valid     = ex.valid;
        // A bubble must not write anything downstream
        exMemD.regWrite  = ex.valid & ex.regWrite;
        exMemD.memWrite  = ex.valid & ex.memWrite;
        exMemD.resultSel = ex.resultSel;
        exMemD.aluOut    = aluOut;
        exMemD.rs2       = ex.rs2;
        exMemD.funct3    = ex.funct3;
        exMemD.rd        = ex.rd;
        exMemD.incPc     = ex.incPc;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMemQ.valid    <= 1'b0;
            exMemQ.regWrite <= 1'b0;
            exMemQ.memWrite <= 1'b0;
        end else begin
            exMemQ <= exMemD;
        end
    end

endmodule

`default_nettype wire

//--- src/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module memoryStage (
    input  logic                clk,
    input  logic                rstN,
    input  riscv_pkg::exMem     exMemQ,
    output riscv_pkg::memWb     wb
);

    localparam int memWords = 1 << `DMEM_ADDR_BITS;

    logic [`XLEN_BITS-1:0]      dmem [memWords];

    logic [`DMEM_ADDR_BITS-1:0] wordIdx;
    logic [1:0]                 byteOff;
    logic [1:0]                 laneOff;
    logic [`XLEN_BYTES-1:0]     byteEn;
    logic [`XLEN_BITS-1:0]      wrData;
    logic [`XLEN_BITS-1:0]      rdWord;
    logic [`XLEN_BITS-1:0]      rdShifted;
    logic [`XLEN_BITS-1:0]      loadData;
    logic [`XLEN_BITS-1:0]      result;

    // Upper address bits wrap around the memory
    assign wordIdx = exMemQ.aluOut[`DMEM_ADDR_BITS+1:2];
    assign byteOff = exMemQ.aluOut[1:0];

    // Misaligned halfwords and words are aligned down
    always_comb begin
        case (exMemQ.funct3[1:0])
            2'b00:   laneOff = byteOff;
            2'b01:   laneOff = {byteOff[1], 1'b0};
            default: laneOff = 2'b00;
        endcase
    end

    always_comb begin
        case (exMemQ.funct3[1:0])
            2'b00: begin
                byteEn = `XLEN_BYTES'(4'b0001) << laneOff;
                wrData = {4{exMemQ.rs2[7:0]}};
            end
            2'b01: begin
                byteEn = `XLEN_BYTES'(4'b0011) << laneOff;
                wrData = {2{exMemQ.rs2[15:0]}};
            end
            2'b10: begin
                byteEn = '1;
                wrData = exMemQ.rs2;
            end
            default: begin
                byteEn = '0;
                wrData = exMemQ.rs2;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (exMemQ.memWrite) begin
            for (int lane = 0; lane < `XLEN_BYTES; lane++) begin
                if (byteEn[lane]) begin
                    dmem[wordIdx][lane*8 +: 8] <= wrData[lane*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read so a load sees last cycle's store
    assign rdWord    = dmem[wordIdx];
    assign rdShifted = rdWord >> {laneOff, 3'b000};

    always_comb begin
        case (exMemQ.funct3)
            riscv_pkg::f3Byte:  loadData = {{(`XLEN_BITS-8){rdShifted[7]}}, rdShifted[7:0]};
            riscv_pkg::f3Half:  loadData = {{(`XLEN_BITS-16){rdShifted[15]}}, rdShifted[15:0]};
            riscv_pkg::f3ByteU: loadData = {{(`XLEN_BITS-8){1'b0}}, rdShifted[7:0]};
            riscv_pkg::f3HalfU: loadData = {{(`XLEN_BITS-16){1'b0}}, rdShifted[15:0]};
            default:            loadData = rdWord;
        endcase
    end

    always_comb begin
        case (exMemQ.resultSel)
            riscv_pkg::resLoad:  result = loadData;
            riscv_pkg::resIncPc: result = exMemQ.incPc;
            default:             result = exMemQ.aluOut;
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb.valid    <= 1'b0;
            wb.regWrite <= 1'b0;
        end else begin
            wb.valid    <= exMemQ.valid;
            wb.regWrite <= exMemQ.regWrite;
            wb.rd       <= exMemQ.rd;
            wb.result   <= result;
        end
    end

endmodule

`default_nettype wire

//--- src/backEnd.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module backEnd (
    input  logic                    clk,
    input  logic                    rstN,
    input  riscv_pkg::exBundle      ex,
    output logic                    pcSrc,
    output logic [`XLEN_BITS-1:0]   pcTarget,
    output riscv_pkg::memWb         wb
);

    riscv_pkg::exMem exMemQ;

    // Redirect goes back to fetch in the same cycle
    execute i_execute (
        .clk      (clk),
        .rstN     (rstN),
        .ex       (ex),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .exMemQ   (exMemQ)
    );

    memoryStage i_memoryStage (
        .clk    (clk),
        .rstN   (rstN),
        .exMemQ (exMemQ),
        .wb     (wb)
    );

endmodule

`default_nettype wire

//--- sim/backEnd_properties.sv
`timescale 1ns/1ps
`default_nettype none

module backEnd_properties (
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic redirect,
    input logic regValid,
    input logic regRegWrite,
    input logic regMemWrite
);

    // An empty register slot carries no write enable
    noWriteWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        !regValid |-> !regRegWrite && !regMemWrite)
        else $error("write enable set in an empty stage register");

    validFollows: assert property (@(posedge clk) disable iff (!rstN)
        regValid == $past(inValid))
        else $error("stage register valid does not follow its input");

    redirectNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> inValid)
        else $error("redirect raised without a valid instruction");

endmodule

bind execute backEnd_properties exChecks (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (ex.valid),
    .redirect    (pcSrc),
    .regValid    (exMemQ.valid),
    .regRegWrite (exMemQ.regWrite),
    .regMemWrite (exMemQ.memWrite)
);

bind memoryStage backEnd_properties memChecks (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (exMemQ.valid),
    .redirect    (1'b0),
    .regValid    (wb.valid),
    .regRegWrite (wb.regWrite),
    .regMemWrite (1'b0)
);

`default_nettype wire

//--- sim/backEnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module backEnd_tb;

    localparam int resetCycles = 10;
    // Lead bubbles, ALU, branch, jump, memory init, store/load pairs, mixed phase with bubbles
    localparam int maxIssued  = 3 + 11 * 12 + 6 * 12 + 16 + 16 + 60 * 2 + 60 * 2;
    localparam int cycleLimit = resetCycles + maxIssued + 50;

    localparam logic [2:0] branchCodes [6] = '{riscv_pkg::f3Beq, riscv_pkg::f3Bne,
        riscv_pkg::f3Blt, riscv_pkg::f3Bge, riscv_pkg::f3Bltu, riscv_pkg::f3Bgeu};
    localparam logic [2:0] storeCodes [3] = '{riscv_pkg::f3Byte, riscv_pkg::f3Half,
        riscv_pkg::f3Word};
    localparam logic [2:0] loadCodes [5] = '{riscv_pkg::f3Byte, riscv_pkg::f3Half,
        riscv_pkg::f3Word, riscv_pkg::f3ByteU, riscv_pkg::f3HalfU};

    logic                   clk;
    logic                   rstN;
    riscv_pkg::exBundle     ex;
    logic                   pcSrc;
    logic [`XLEN_BITS-1:0]  pcTarget;
    riscv_pkg::memWb        wb;

    integer                 seed;
    int                     cycleCount = 0;
    int                     errorCount = 0;
    int                     checkCount = 0;

    // Data memory model
    // Only words 0 to 15 are ever loaded
    logic [`XLEN_BITS-1:0]  refMem [1 << `DMEM_ADDR_BITS];

    // Expected writeback with the cycle it is due on wb
    riscv_pkg::memWb        expWbQ [$];
    int                     dueQ [$];
    riscv_pkg::memWb        expHead;

    // Expected redirect of the instruction now on ex
    logic                   curSrc;
    logic [`XLEN_BITS-1:0]  curTarget;
    logic                   curValid;

    backEnd i_backEnd (
        .clk      (clk),
        .rstN     (rstN),
        .ex       (ex),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [`XLEN_BITS-1:0] randWord();
        randWord = $random(seed);
    endfunction

    function automatic riscv_pkg::exBundle blankBundle();
        riscv_pkg::exBundle e;
        logic [`XLEN_BITS-1:0] r;
        e = '0;
        e.valid = 1'b1;
        e.rs1 = randWord();
        e.rs2 = randWord();
        e.imm = randWord();
        r = randWord();
        e.pc = {r[31:2], 2'b00};
        e.incPc = e.pc + 32'd4;
        e.rd = r[6:2];
        e.aluCtrl = riscv_pkg::aluAdd;
        e.resultSel = riscv_pkg::resAlu;
        return e;
    endfunction

    function automatic riscv_pkg::exBundle aluInstr(input riscv_pkg::aluOp op, input logic useImm);
        riscv_pkg::exBundle e;
        e = blankBundle();
        e.aluCtrl = op;
        e.srcBSel = useImm;
        e.regWrite = 1'b1;
        return e;
    endfunction

    function automatic riscv_pkg::exBundle branchInstr(input logic [2:0] f3, input logic equal);
        riscv_pkg::exBundle e;
        e = blankBundle();
        e.branch = 1'b1;
        e.srcASel = 1'b1;
        e.srcBSel = 1'b1;
        e.funct3 = f3;
        if (equal) begin
            e.rs2 = e.rs1;
        end
        return e;
    endfunction

    // jal adds to the PC, jalr adds to rs1
    function automatic riscv_pkg::exBundle jumpInstr(input logic isJalr);
        riscv_pkg::exBundle e;
        e = blankBundle();
        e.jump = 1'b1;
        e.regWrite = 1'b1;
        e.srcASel = !isJalr;
        e.srcBSel = 1'b1;
        e.resultSel = riscv_pkg::resIncPc;
        return e;
    endfunction

    // Address has random upper bits so the word index wraps
    function automatic riscv_pkg::exBundle memInstr(input logic isStore, input logic [2:0] f3,
                                                    input logic [3:0] word, input logic [1:0] off);
        riscv_pkg::exBundle e;
        logic [`XLEN_BITS-1:0] addr;
        e = blankBundle();
        addr = randWord();
        addr[`DMEM_ADDR_BITS+1:2] = '0;
        addr[5:0] = {word, off};
        e.imm = addr - e.rs1;
        e.srcBSel = 1'b1;
        e.funct3 = f3;
        e.memWrite = isStore;
        e.regWrite = !isStore;
        if (!isStore) begin
            e.resultSel = riscv_pkg::resLoad;
        end
        return e;
    endfunction

    // A bubble aimed at live memory with every enable set
    function automatic riscv_pkg::exBundle bubble();
        riscv_pkg::exBundle e;
        e = memInstr(1'b1, riscv_pkg::f3Word, randWord() % 16, 2'b00);
        e.valid = 1'b0;
        e.jump = 1'b1;
        e.branch = 1'b1;
        e.regWrite = 1'b1;
        return e;
    endfunction

    function automatic void modelInstr(
        input  riscv_pkg::exBundle      e,
        output logic                    expSrc,
        output logic [`XLEN_BITS-1:0]   expTarget,
        output riscv_pkg::memWb         expWb
    );
        logic [`XLEN_BITS-1:0]      a;
        logic [`XLEN_BITS-1:0]      b;
        logic [`XLEN_BITS-1:0]      res;
        logic [`XLEN_BITS-1:0]      word;
        logic [`XLEN_BITS-1:0]      loadVal;
        logic [`XLEN_BITS-1:0]      wbVal;
        logic [7:0]                 lb;
        logic [15:0]                lh;
        logic                       taken;
        logic [`DMEM_ADDR_BITS-1:0] idx;
        a = e.srcASel ? e.pc : e.rs1;
        b = e.srcBSel ? e.imm : e.rs2;
        case (e.aluCtrl)
            riscv_pkg::aluAdd:   res = a + b;
            riscv_pkg::aluSub:   res = a - b;
            riscv_pkg::aluSll:   res = a << b[4:0];
            riscv_pkg::aluSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            riscv_pkg::aluSltu:  res = (a < b) ? 32'd1 : 32'd0;
            riscv_pkg::aluXor:   res = a ^ b;
            riscv_pkg::aluSrl:   res = a >> b[4:0];
            riscv_pkg::aluSra:   res = $signed(a) >>> b[4:0];
            riscv_pkg::aluOr:    res = a | b;
            riscv_pkg::aluAnd:   res = a & b;
            riscv_pkg::aluPassB: res = b;
            default:             res = '0;
        endcase
        case (e.funct3)
            riscv_pkg::f3Beq:  taken = e.rs1 == e.rs2;
            riscv_pkg::f3Bne:  taken = e.rs1 != e.rs2;
            riscv_pkg::f3Blt:  taken = $signed(e.rs1) < $signed(e.rs2);
            riscv_pkg::f3Bge:  taken = $signed(e.rs1) >= $signed(e.rs2);
            riscv_pkg::f3Bltu: taken = e.rs1 < e.rs2;
            riscv_pkg::f3Bgeu: taken = e.rs1 >= e.rs2;
            default:           taken = 1'b0;
        endcase
        expSrc = e.valid && (e.jump || (e.branch && taken));
        expTarget = res;
        idx = res[`DMEM_ADDR_BITS+1:2];
        word = refMem[idx];
        lb = word[{res[1:0], 3'b000} +: 8];
        lh = word[{res[1], 4'b0000} +: 16];
        case (e.funct3)
            riscv_pkg::f3Byte:  loadVal = {{24{lb[7]}}, lb};
            riscv_pkg::f3Half:  loadVal = {{16{lh[15]}}, lh};
            riscv_pkg::f3ByteU: loadVal = {24'd0, lb};
            riscv_pkg::f3HalfU: loadVal = {16'd0, lh};
            default:            loadVal = word;
        endcase
        if (e.valid && e.memWrite) begin
            case (e.funct3[1:0])
                2'b00:   refMem[idx][{res[1:0], 3'b000} +: 8] = e.rs2[7:0];
                2'b01:   refMem[idx][{res[1], 4'b0000} +: 16] = e.rs2[15:0];
                2'b10:   refMem[idx] = e.rs2;
                default: ;
            endcase
        end
        case (e.resultSel)
            riscv_pkg::resLoad:  wbVal = loadVal;
            riscv_pkg::resIncPc: wbVal = e.incPc;
            default:             wbVal = res;
        endcase
        expWb.valid = e.valid;
        expWb.regWrite = e.valid && e.regWrite;
        expWb.rd = e.rd;
        expWb.result = wbVal;
    endfunction

    task automatic issue(input riscv_pkg::exBundle e);
        logic                   expSrc;
        logic [`XLEN_BITS-1:0]  expTarget;
        riscv_pkg::memWb        expWb;
        @(posedge clk);
        #1;
        ex = e;
        modelInstr(e, expSrc, expTarget, expWb);
        curSrc = expSrc;
        curTarget = expTarget;
        curValid = e.valid;
        expWbQ.push_back(expWb);
        dueQ.push_back(cycleCount + 2);
    endtask

    task automatic flagMismatch(input string name, input logic [31:0] got, input logic [31:0] expv);
        errorCount++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, expv, $time);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no end of test after %0d cycles", cycleLimit);
            $display("checks %0d errors %0d", checkCount, errorCount);
            $display("sim failed");
            $finish;
        end
    end

    // Compare in the middle of the cycle where ex and wb are stable
    always @(negedge clk) begin
        if (rstN) begin
            checkCount++;
            if (pcSrc !== curSrc) flagMismatch("pcSrc", 32'(pcSrc), 32'(curSrc));
            if (curValid && pcTarget !== curTarget) flagMismatch("pcTarget", pcTarget, curTarget);
            if (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
                expHead = expWbQ.pop_front();
                void'(dueQ.pop_front());
                if (wb.valid !== expHead.valid) begin
                    flagMismatch("wb.valid", 32'(wb.valid), 32'(expHead.valid));
                end
                if (wb.regWrite !== expHead.regWrite) begin
                    flagMismatch("wb.regWrite", 32'(wb.regWrite), 32'(expHead.regWrite));
                end
                if (expHead.valid && wb.rd !== expHead.rd) begin
                    flagMismatch("wb.rd", 32'(wb.rd), 32'(expHead.rd));
                end
                if (expHead.valid && wb.result !== expHead.result) begin
                    flagMismatch("wb.result", wb.result, expHead.result);
                end
            end else if (wb.valid !== 1'b0 || wb.regWrite !== 1'b0) begin
                errorCount++;
                $display("writeback active with no instruction in flight at %0t", $time);
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          opIdx;
        seed = 32'haecd_d751;
        rstN = 1'b0;
        ex = '0;
        curSrc = 1'b0;
        curTarget = '0;
        curValid = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (3) issue(bubble());
        for (int op = 0; op < 11; op++) begin
            for (int n = 0; n < 12; n++) begin
                issue(aluInstr(riscv_pkg::aluOp'(op[3:0]), n >= 6));
            end
        end
        for (int i = 0; i < 6; i++) begin
            for (int n = 0; n < 12; n++) begin
                issue(branchInstr(branchCodes[i], n >= 8));
            end
        end
        for (int n = 0; n < 16; n++) begin
            issue(jumpInstr(n[0]));
        end
        // Every loaded word gets a full store first
        for (int w = 0; w < 16; w++) begin
            issue(memInstr(1'b1, riscv_pkg::f3Word, w[3:0], 2'b00));
        end
        for (int n = 0; n < 60; n++) begin
            r = randWord();
            issue(memInstr(1'b1, storeCodes[int'(r[5:4]) % 3], r[3:0], r[7:6]));
            issue(memInstr(1'b0, loadCodes[int'(r[10:8]) % 5], r[3:0], r[12:11]));
        end
        for (int n = 0; n < 60; n++) begin
            r = randWord();
            opIdx = int'(r[6:3]) % 11;
            case (r[2:0])
                3'd0, 3'd1, 3'd2: issue(aluInstr(riscv_pkg::aluOp'(opIdx[3:0]), r[7]));
                3'd3:    issue(branchInstr(branchCodes[int'(r[10:8]) % 6], r[7]));
                3'd4:    issue(jumpInstr(r[9]));
                3'd5:    issue(memInstr(1'b1, storeCodes[opIdx % 3], r[14:11], r[16:15]));
                default: issue(memInstr(1'b0, loadCodes[opIdx % 5], r[14:11], r[16:15]));
            endcase
            if (r[20]) issue(bubble());
        end
        @(posedge clk);
        #1;
        ex = '0;
        curSrc = 1'b0;
        curValid = 1'b0;
        // Wait on rising edges so the last compare has finished before the report
        while (dueQ.size() != 0) @(posedge clk);
        @(posedge clk);
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/riscv_pkg.sv
src/alu.sv
src/branchCompare.sv
src/execute.sv
src/memoryStage.sv
src/backEnd.sv
sim/backEnd_properties.sv
sim/backEnd_tb.sv

//--- run.sh
#!/bin/sh
# Build the back end testbench with Verilator and run it

rm -rf obj_dir sim.log

verilator --binary --assert -f verilog.f --top-module backEnd_tb -o backEnd_sim \
    && ./obj_dir/backEnd_sim > sim.log 2>&1 \
    || echo "sim failed" >> sim.log

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
